//--- Makefile
# Verilator build for the SoC harness testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_harness
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/bootrom.hex
// boot ROM image: one 64-bit word per line, ROM word address 0 to 15
0202859300000297
f140257330529073
0182b28300000013
0000806700028067
1050007300000013
ffdff06f10500073
3010257334151073
0080006f00000013
00a5b02300b50533
fe059ce3fff58593
00100293300022f3
30429073008282b3
0000100f0000000f
34202573fc1ff06f
deadbeefcafef00d
0123456789abcdef

//--- hw/bootrom.sv
/*
 * Boot ROM. Sixteen 64-bit words loaded from the boot hex image,
 * read with one cycle of latency.
 */

`timescale 1ns/100ps

module bootrom import harness_pkg::*; (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic [RomAddrWidth-1:0] addr_i,
  output logic [DataWidth-1:0]    rdata_o
);

  logic [DataWidth-1:0] mem [RomWords];

  // boot image
  initial begin
    $readmemh("hw/bootrom.hex", mem);
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

//--- hw/bus_demux.sv
/*
 * Bus address decoder. Sends each request to the ROM, CLINT or DRAM and
 * returns the chosen target's read data one cycle later, or an error.
 */

`timescale 1ns/100ps

module bus_demux import harness_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [AddrWidth-1:0]      addr_i,
  output logic                      rvalid_o,
  output logic [DataWidth-1:0]      rdata_o,
  output logic                      err_o,
  output logic                      rom_req_o,
  output logic [RomAddrWidth-1:0]   rom_addr_o,
  input  logic [DataWidth-1:0]      rom_rdata_i,
  output logic                      clint_req_o,
  output logic [ClintAddrWidth-1:0] clint_addr_o,
  input  logic [DataWidth-1:0]      clint_rdata_i,
  output logic                      dram_req_o,
  output logic [DramAddrWidth-1:0]  dram_addr_o,
  input  logic [DataWidth-1:0]      dram_rdata_i
);

  target_e              target_d;
  target_e              target_q;
  logic                 dec_err;
  logic                 rvalid_q;
  logic                 err_q;
  logic [AddrWidth-1:0] rom_off;
  logic [AddrWidth-1:0] clint_off;
  logic [AddrWidth-1:0] dram_off;

  // --------------------------------------------------
  // decode
  // --------------------------------------------------
  always_comb begin
    target_d = TargetNone;
    if (addr_i >= RomBase && addr_i < RomBase + RomLength) begin
      target_d = TargetRom;
    end else if (addr_i >= ClintBase && addr_i < ClintBase + ClintLength) begin
      target_d = TargetClint;
    end else if (addr_i >= DramBase && addr_i < DramBase + DramLength) begin
      target_d = TargetDram;
    end
  end

  // unmapped, or a write to read-only memory
  assign dec_err = (target_d == TargetNone) || (target_d == TargetRom && we_i);

  assign rom_off   = addr_i - RomBase;
  assign clint_off = addr_i - ClintBase;
  assign dram_off  = addr_i - DramBase;

  assign rom_req_o    = req_i && target_d == TargetRom && !we_i;
  assign rom_addr_o   = rom_off[RomAddrWidth+2:3];
  assign clint_req_o  = req_i && target_d == TargetClint;
  assign clint_addr_o = clint_off[ClintOffWidth-1:3];
  assign dram_req_o   = req_i && target_d == TargetDram;
  assign dram_addr_o  = dram_off[DramAddrWidth+2:3];

  // --------------------------------------------------
  // response
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      target_q <= TargetNone;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & dec_err;
      if (req_i) begin
        target_q <= target_d;
      end
    end
  end

  always_comb begin
    case (target_q)
      TargetRom:   rdata_o = rom_rdata_i;
      TargetClint: rdata_o = clint_rdata_i;
      TargetDram:  rdata_o = dram_rdata_i;
      default:     rdata_o = '0;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule

//--- hw/clint_timer.sv
/*
 * Core-local interruptor. Holds msip, mtimecmp and mtime; mtime counts
 * synchronized rising edges of the real-time clock.
 */

`timescale 1ns/100ps

module clint_timer import harness_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      rtc_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [ClintAddrWidth-1:0] addr_i,
  input  logic [BeWidth-1:0]        be_i,
  input  logic [DataWidth-1:0]      wdata_i,
  output logic [DataWidth-1:0]      rdata_o,
  output logic                      timer_irq_o,
  output logic                      ipi_o
);

  logic                 msip_q;
  logic [DataWidth-1:0] mtimecmp_q;
  logic [DataWidth-1:0] mtime_q;
  logic [1:0]           rtc_sync_q;
  logic                 rtc_prev_q;
  logic                 rtc_tick;
  logic                 sel_msip;
  logic                 sel_mtimecmp;
  logic                 sel_mtime;
  logic [DataWidth-1:0] rd_val;

  function automatic logic [DataWidth-1:0] be_merge(
    input logic [DataWidth-1:0] old_val,
    input logic [DataWidth-1:0] new_val,
    input logic [BeWidth-1:0]   be
  );
    logic [DataWidth-1:0] res;
    res = old_val;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign sel_msip     = (addr_i == MsipOffset[ClintOffWidth-1:3]);
  assign sel_mtimecmp = (addr_i == MtimecmpOffset[ClintOffWidth-1:3]);
  assign sel_mtime    = (addr_i == MtimeOffset[ClintOffWidth-1:3]);

  // --------------------------------------------------
  // rtc edge detect
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
    end
  end

  assign rtc_tick = rtc_sync_q[1] & ~rtc_prev_q;

  // --------------------------------------------------
  // registers
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (req_i && we_i && sel_msip && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      if (req_i && we_i && sel_mtimecmp) begin
        mtimecmp_q <= be_merge(mtimecmp_q, wdata_i, be_i);
      end
      // a bus write wins over a tick
      if (req_i && we_i && sel_mtime) begin
        mtime_q <= be_merge(mtime_q, wdata_i, be_i);
      end else if (rtc_tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  always_comb begin
    rd_val = '0;
    if (sel_msip) begin
      rd_val = {{(DataWidth-1){1'b0}}, msip_q};
    end else if (sel_mtimecmp) begin
      rd_val = mtimecmp_q;
    end else if (sel_mtime) begin
      rd_val = mtime_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rd_val;
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

//--- hw/dbg_gate.sv
/*
 * Debug request gate. Masks the halt request for a fixed number of cycles
 * after power-on so the boot code can run, and while debug is disabled.
 */

`timescale 1ns/100ps

module dbg_gate import harness_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic halt_req_i,
  output logic debug_req_o
);

  logic [DbgCntWidth-1:0] cnt_q;
  logic                   holdoff_done;

  assign holdoff_done = (cnt_q == '0);

  // down-counter, stops at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= DbgCntWidth'(DbgHoldoffCycles);
    end else if (!holdoff_done) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = holdoff_done & enable_i & halt_req_i;

endmodule

//--- hw/dram_mem.sv
/*
 * Main memory. Single-port synchronous RAM with per-byte write enables;
 * every access returns the word held before the access.
 */

`timescale 1ns/100ps

module dram_mem import harness_pkg::*; #(
  parameter int unsigned NumWords = 1024
) (
  input  logic                        clk_i,
  input  logic                        req_i,
  input  logic                        we_i,
  input  logic [$clog2(NumWords)-1:0] addr_i,
  input  logic [BeWidth-1:0]          be_i,
  input  logic [DataWidth-1:0]        wdata_i,
  output logic [DataWidth-1:0]        rdata_o
);

  logic [DataWidth-1:0] mem [NumWords];

  // --------------------------------------------------
  // read port
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= mem[addr_i];
    end
  end

  // --------------------------------------------------
  // write port
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < BeWidth; b++) begin
        // only enabled lanes change
        if (be_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- hw/harness_pkg.sv
/*
 * Harness package. Bus widths, the address map of the ROM, CLINT and DRAM,
 * CLINT register offsets, interrupt bit positions and the debug hold-off.
 */

package harness_pkg;

  // --------------------------------------------------
  // bus widths and memory sizes
  // --------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned BeWidth   = DataWidth / 8;
  localparam int unsigned DramWords = 1024;
  localparam int unsigned RomWords  = 16;

  // word address widths seen by each target
  localparam int unsigned RomAddrWidth   = $clog2(RomWords);
  localparam int unsigned DramAddrWidth  = $clog2(DramWords);
  localparam int unsigned ClintOffWidth  = 20;
  localparam int unsigned ClintAddrWidth = ClintOffWidth - 3;

  // --------------------------------------------------
  // address map
  // --------------------------------------------------
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h000C_0000;
  localparam logic [AddrWidth-1:0] DramBase    = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] DramLength  = AddrWidth'(DramWords * 8);

  // clint byte offsets
  localparam logic [ClintOffWidth-1:0] MsipOffset     = 20'h0_0000;
  localparam logic [ClintOffWidth-1:0] MtimecmpOffset = 20'h0_4000;
  localparam logic [ClintOffWidth-1:0] MtimeOffset    = 20'h0_BFF8;

  // --------------------------------------------------
  // interrupt pending vector
  // --------------------------------------------------
  localparam int unsigned XLen    = 64;
  localparam int unsigned IrqMsip = 3;
  localparam int unsigned IrqMtip = 7;
  localparam int unsigned IrqSeip = 9;
  localparam int unsigned IrqMeip = 11;

  // cycles the debug request stays masked after power-on
  localparam int unsigned DbgHoldoffCycles = 50;
  localparam int unsigned DbgCntWidth      = $clog2(DbgHoldoffCycles + 1);

  typedef enum logic [1:0] {
    TargetRom,
    TargetClint,
    TargetDram,
    TargetNone
  } target_e;

endpackage

//--- hw/rst_sync.sv
/*
 * Peripheral reset generator. Power-on reset or a non-debug-module reset
 * request asserts the output at once; release is synchronized to the clock.
 */

`timescale 1ns/100ps

module rst_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_req_i,
  output logic rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // either source pulls the chain low
  assign rst_comb_n = rst_ni & ~ndmreset_req_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_no = sync_q[1];

endmodule

//--- hw/soc_harness.sv
/*
 * SoC harness top. Memory and interrupt side of the system: reset and
 * debug gating, bus decode to ROM, DRAM and CLINT, and the mip vector.
 */

`timescale 1ns/100ps

module soc_harness import harness_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rtc_i,
  input  logic                 ndmreset_req_i,
  input  logic                 dbg_enable_i,
  input  logic                 dbg_halt_req_i,
  input  logic [1:0]           ext_irq_i,
  input  logic                 bus_req_i,
  input  logic                 bus_we_i,
  input  logic [AddrWidth-1:0] bus_addr_i,
  input  logic [BeWidth-1:0]   bus_be_i,
  input  logic [DataWidth-1:0] bus_wdata_i,
  output logic                 bus_rvalid_o,
  output logic [DataWidth-1:0] bus_rdata_o,
  output logic                 bus_err_o,
  output logic                 debug_req_o,
  output logic [XLen-1:0]      mip_o,
  output logic                 core_rst_no
);

  logic                      periph_rst_n;
  logic                      rom_req;
  logic [RomAddrWidth-1:0]   rom_addr;
  logic [DataWidth-1:0]      rom_rdata;
  logic                      clint_req;
  logic [ClintAddrWidth-1:0] clint_addr;
  logic [DataWidth-1:0]      clint_rdata;
  logic                      dram_req;
  logic [DramAddrWidth-1:0]  dram_addr;
  logic [DataWidth-1:0]      dram_rdata;
  logic                      timer_irq;
  logic                      ipi;

  // --------------------------------------------------
  // reset and debug
  // --------------------------------------------------
  rst_sync i_rst_sync (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .ndmreset_req_i ( ndmreset_req_i ),
    .rst_no         ( periph_rst_n   )
  );

  assign core_rst_no = periph_rst_n;

  // power-on reset only, ndmreset must not restart the hold-off
  dbg_gate i_dbg_gate (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .enable_i    ( dbg_enable_i   ),
    .halt_req_i  ( dbg_halt_req_i ),
    .debug_req_o ( debug_req_o    )
  );

  // --------------------------------------------------
  // bus and targets
  // --------------------------------------------------
  bus_demux i_bus_demux (
    .clk_i         ( clk_i        ),
    .rst_ni        ( periph_rst_n ),
    .req_i         ( bus_req_i    ),
    .we_i          ( bus_we_i     ),
    .addr_i        ( bus_addr_i   ),
    .rvalid_o      ( bus_rvalid_o ),
    .rdata_o       ( bus_rdata_o  ),
    .err_o         ( bus_err_o    ),
    .rom_req_o     ( rom_req      ),
    .rom_addr_o    ( rom_addr     ),
    .rom_rdata_i   ( rom_rdata    ),
    .clint_req_o   ( clint_req    ),
    .clint_addr_o  ( clint_addr   ),
    .clint_rdata_i ( clint_rdata  ),
    .dram_req_o    ( dram_req     ),
    .dram_addr_o   ( dram_addr    ),
    .dram_rdata_i  ( dram_rdata   )
  );

  bootrom i_bootrom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( rom_addr  ),
    .rdata_o ( rom_rdata )
  );

  dram_mem #(
    .NumWords ( DramWords )
  ) i_dram_mem (
    .clk_i   ( clk_i       ),
    .req_i   ( dram_req    ),
    .we_i    ( bus_we_i    ),
    .addr_i  ( dram_addr   ),
    .be_i    ( bus_be_i    ),
    .wdata_i ( bus_wdata_i ),
    .rdata_o ( dram_rdata  )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i        ),
    .rst_ni      ( periph_rst_n ),
    .rtc_i       ( rtc_i        ),
    .req_i       ( clint_req    ),
    .we_i        ( bus_we_i     ),
    .addr_i      ( clint_addr   ),
    .be_i        ( bus_be_i     ),
    .wdata_i     ( bus_wdata_i  ),
    .rdata_o     ( clint_rdata  ),
    .timer_irq_o ( timer_irq    ),
    .ipi_o       ( ipi          )
  );

  // ext_irq_i[0] is the machine external line
  always_comb begin
    mip_o          = '0;
    mip_o[IrqMsip] = ipi;
    mip_o[IrqMtip] = timer_irq;
    mip_o[IrqSeip] = ext_irq_i[1];
    mip_o[IrqMeip] = ext_irq_i[0];
  end

endmodule

//--- test/soc_harness_props.sv
/*
 * Bus and debug properties of the SoC harness, bound into the top level.
 */

`timescale 1ns/100ps

module soc_harness_props import harness_pkg::*; (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 core_rst_no,
  input logic                 bus_req_i,
  input logic [AddrWidth-1:0] bus_addr_i,
  input logic                 bus_rvalid_o,
  input logic                 bus_err_o,
  input logic                 debug_req_o
);

  logic [DbgCntWidth-1:0] holdoff_q;
  target_e                tgt_q;

  // target of an address, straight from the memory map
  function automatic target_e decode(input logic [AddrWidth-1:0] addr);
    if (addr - RomBase < RomLength) begin
      return TargetRom;
    end
    if (addr - ClintBase < ClintLength) begin
      return TargetClint;
    end
    if (addr - DramBase < DramLength) begin
      return TargetDram;
    end
    return TargetNone;
  endfunction

  // cycles since power-on, saturating at the hold-off
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      holdoff_q <= '0;
    end else if (holdoff_q < DbgCntWidth'(DbgHoldoffCycles)) begin
      holdoff_q <= holdoff_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge core_rst_no) begin
    if (!core_rst_no) begin
      tgt_q <= TargetNone;
    end else if (bus_req_i) begin
      tgt_q <= decode(bus_addr_i);
    end
  end

  // --------------------------------------------------
  // properties
  // --------------------------------------------------
  rvalid_after_req: assert property (@(posedge clk_i) disable iff (!core_rst_no)
    bus_req_i |=> bus_rvalid_o)
    else $error("bus_rvalid_o missing one cycle after bus_req_i");

  rvalid_only_after_req: assert property (@(posedge clk_i) disable iff (!core_rst_no)
    !bus_req_i |=> !bus_rvalid_o)
    else $error("bus_rvalid_o without a request");

  err_with_rvalid: assert property (@(posedge clk_i) bus_err_o |-> bus_rvalid_o)
    else $error("bus_err_o outside a response");

  unmapped_err: assert property (@(posedge clk_i) disable iff (!core_rst_no)
    (bus_rvalid_o && tgt_q == TargetNone) |-> bus_err_o)
    else $error("unmapped access answered without bus_err_o");

  no_debug_in_holdoff: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (holdoff_q < DbgCntWidth'(DbgHoldoffCycles)) |-> !debug_req_o)
    else $error("debug_req_o raised during the hold-off");

endmodule

//--- test/tb_soc_harness.sv
/*
 * SoC harness testbench. Plays the hart on the bus and runs directed tests
 * of the debug hold-off, DRAM, boot ROM, CLINT, mip packing and ndmreset.
 */

`timescale 1ns/100ps

module tb_soc_harness import harness_pkg::*; ();

  logic                 clk_i;
  logic                 rst_ni;
  logic                 rtc_i;
  logic                 ndmreset_req_i;
  logic                 dbg_enable_i;
  logic                 dbg_halt_req_i;
  logic [1:0]           ext_irq_i;
  logic                 bus_req_i;
  logic                 bus_we_i;
  logic [AddrWidth-1:0] bus_addr_i;
  logic [BeWidth-1:0]   bus_be_i;
  logic [DataWidth-1:0] bus_wdata_i;
  logic                 bus_rvalid_o;
  logic [DataWidth-1:0] bus_rdata_o;
  logic                 bus_err_o;
  logic                 debug_req_o;
  logic [XLen-1:0]      mip_o;
  logic                 core_rst_no;

  logic [DataWidth-1:0] rom_model  [RomWords];
  logic [DataWidth-1:0] dram_model [DramWords];
  int                   errors;
  int                   tests_run;
  int                   tests_failed;

  soc_harness soc_harness_i (.*);

  bind soc_harness soc_harness_props props_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .core_rst_no  ( core_rst_no  ),
    .bus_req_i    ( bus_req_i    ),
    .bus_addr_i   ( bus_addr_i   ),
    .bus_rvalid_o ( bus_rvalid_o ),
    .bus_err_o    ( bus_err_o    ),
    .debug_req_o  ( debug_req_o  )
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("ERROR at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  function automatic logic [AddrWidth-1:0] dram_addr(input int unsigned idx);
    return DramBase + AddrWidth'(idx * 8);
  endfunction

  function automatic logic [AddrWidth-1:0] clint_addr(input logic [19:0] off);
    return ClintBase + AddrWidth'(off);
  endfunction

  // one bit per byte lane widened to a data mask
  function automatic logic [DataWidth-1:0] byte_mask(input logic [BeWidth-1:0] be);
    logic [DataWidth-1:0] mask;
    for (int b = 0; b < BeWidth; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return mask;
  endfunction

  // single access, called on a falling edge and returns on one
  task automatic bus_access(input logic we, input logic [AddrWidth-1:0] addr,
                            input logic [BeWidth-1:0] be, input logic [DataWidth-1:0] wdata,
                            output logic [DataWidth-1:0] rdata, output logic err);
    int waited;
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    @(negedge clk_i);
    bus_req_i = 1'b0;
    waited    = 1;
    while (!bus_rvalid_o && waited < 20) begin
      @(negedge clk_i);
      waited++;
    end
    if (!bus_rvalid_o) begin
      abort_run("no bus_rvalid_o after a request");
    end
    if (waited != 1) begin
      report_mismatch("bus_rvalid_o latency", 64'(waited), 64'd1);
    end
    rdata = bus_rdata_o;
    err   = bus_err_o;
  endtask

  task automatic bus_write(input logic [AddrWidth-1:0] addr, input logic [BeWidth-1:0] be,
                           input logic [DataWidth-1:0] wdata);
    logic [DataWidth-1:0] rdata;
    logic                 err;
    bus_access(1'b1, addr, be, wdata, rdata, err);
    if (err !== 1'b0) begin
      report_mismatch("bus_err_o", 64'(err), 64'd0);
    end
  endtask

  task automatic read_expect(input logic [AddrWidth-1:0] addr,
                             input logic [DataWidth-1:0] exp, input string name);
    logic [DataWidth-1:0] rdata;
    logic                 err;
    bus_access(1'b0, addr, '1, '0, rdata, err);
    if (err !== 1'b0) begin
      report_mismatch("bus_err_o", 64'(err), 64'd0);
    end
    if (rdata !== exp) begin
      report_mismatch(name, rdata, exp);
    end
  endtask

  task automatic expect_error(input logic we, input logic [AddrWidth-1:0] addr);
    logic [DataWidth-1:0] rdata;
    logic                 err;
    bus_access(we, addr, '1, {$urandom, $urandom}, rdata, err);
    if (err !== 1'b1) begin
      report_mismatch("bus_err_o", 64'(err), 64'd1);
    end
  endtask

  // write, then read the same word on the next cycle
  task automatic write_then_read(input logic [AddrWidth-1:0] addr,
                                 input logic [DataWidth-1:0] wdata);
    bus_req_i   = 1'b1;
    bus_we_i    = 1'b1;
    bus_addr_i  = addr;
    bus_be_i    = '1;
    bus_wdata_i = wdata;
    @(negedge clk_i);
    if (bus_rvalid_o !== 1'b1) begin
      report_mismatch("bus_rvalid_o", 64'(bus_rvalid_o), 64'd1);
    end
    bus_we_i = 1'b0;
    @(negedge clk_i);
    bus_req_i = 1'b0;
    if (bus_rvalid_o !== 1'b1) begin
      report_mismatch("bus_rvalid_o", 64'(bus_rvalid_o), 64'd1);
    end
    if (bus_rdata_o !== wdata) begin
      report_mismatch("bus_rdata_o", bus_rdata_o, wdata);
    end
    @(negedge clk_i);
    if (bus_rvalid_o !== 1'b0) begin
      report_mismatch("bus_rvalid_o", 64'(bus_rvalid_o), 64'd0);
    end
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  task automatic test_debug_holdoff();
    int err_start;
    int cycles;
    err_start = errors;
    cycles    = 0;
    while (!debug_req_o && cycles < DbgHoldoffCycles + 10) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!debug_req_o) begin
      abort_run("debug_req_o never rose after the hold-off");
    end
    if (cycles != DbgHoldoffCycles) begin
      report_mismatch("debug_req_o rise cycle", 64'(cycles), 64'(DbgHoldoffCycles));
    end
    dbg_enable_i = 1'b0;
    #1;
    if (debug_req_o !== 1'b0) begin
      report_mismatch("debug_req_o", 64'(debug_req_o), 64'd0);
    end
    @(negedge clk_i);
    finish_test("debug hold-off", err_start);
  endtask

  task automatic test_dram();
    int                   err_start;
    int unsigned          idx;
    int unsigned          used [$];
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] mask;
    err_start = errors;
    for (int i = 0; i < 12; i++) begin
      idx   = $urandom % DramWords;
      wdata = {$urandom, $urandom};
      bus_write(dram_addr(idx), '1, wdata);
      dram_model[idx] = wdata;
      be    = BeWidth'($urandom);
      wdata = {$urandom, $urandom};
      bus_write(dram_addr(idx), be, wdata);
      mask            = byte_mask(be);
      dram_model[idx] = (dram_model[idx] & ~mask) | (wdata & mask);
      read_expect(dram_addr(idx), dram_model[idx], "bus_rdata_o");
      used.push_back(idx);
    end
    // nothing else got disturbed
    foreach (used[k]) begin
      read_expect(dram_addr(used[k]), dram_model[used[k]], "bus_rdata_o");
    end
    for (int i = 0; i < 3; i++) begin
      idx             = $urandom % DramWords;
      dram_model[idx] = {$urandom, $urandom};
      write_then_read(dram_addr(idx), dram_model[idx]);
    end
    finish_test("dram", err_start);
  endtask

  task automatic test_rom_and_errors();
    int err_start;
    err_start = errors;
    for (int i = 0; i < RomWords; i++) begin
      read_expect(RomBase + AddrWidth'(i * 8), rom_model[i], "bus_rdata_o");
    end
    expect_error(1'b1, RomBase + 32'h8);
    expect_error(1'b0, 32'h0000_0000);
    expect_error(1'b1, RomBase + RomLength);
    expect_error(1'b0, ClintBase + ClintLength);
    expect_error(1'b1, DramBase + DramLength);
    expect_error(1'b0, 32'h1000_0000 + ($urandom % 32'h6000_0000));
    finish_test("rom and errors", err_start);
  endtask

  task automatic test_clint_timer();
    int          err_start;
    int unsigned ticks;
    err_start = errors;
    ticks     = 3 + $urandom % 6;
    read_expect(clint_addr(MtimeOffset), 64'd0, "mtime");
    if (mip_o[IrqMtip] !== 1'b0) begin
      report_mismatch("mip_o mtip", 64'(mip_o[IrqMtip]), 64'd0);
    end
    // slow rtc, one rising edge per loop
    for (int i = 0; i < ticks; i++) begin
      rtc_i = 1'b1;
      repeat (4) @(negedge clk_i);
      rtc_i = 1'b0;
      repeat (4) @(negedge clk_i);
    end
    read_expect(clint_addr(MtimeOffset), 64'(ticks), "mtime");
    bus_write(clint_addr(MtimecmpOffset), '1, 64'(ticks));
    if (mip_o[IrqMtip] !== 1'b1) begin
      report_mismatch("mip_o mtip", 64'(mip_o[IrqMtip]), 64'd1);
    end
    bus_write(clint_addr(MtimecmpOffset), '1, 64'(ticks - 1));
    if (mip_o[IrqMtip] !== 1'b1) begin
      report_mismatch("mip_o mtip", 64'(mip_o[IrqMtip]), 64'd1);
    end
    bus_write(clint_addr(MtimecmpOffset), '1, 64'(ticks + 1));
    if (mip_o[IrqMtip] !== 1'b0) begin
      report_mismatch("mip_o mtip", 64'(mip_o[IrqMtip]), 64'd0);
    end
    read_expect(clint_addr(MtimecmpOffset), 64'(ticks + 1), "mtimecmp");
    finish_test("clint timer", err_start);
  endtask

  task automatic test_irq_packing();
    int              err_start;
    logic [XLen-1:0] exp;
    err_start = errors;
    bus_write(clint_addr(MsipOffset), '1, 64'd1);
    read_expect(clint_addr(MsipOffset), 64'd1, "msip");
    for (int v = 0; v < 4; v++) begin
      ext_irq_i = 2'(v);
      #1;
      exp          = '0;
      exp[IrqMsip] = 1'b1;
      exp[IrqMeip] = ext_irq_i[0];
      exp[IrqSeip] = ext_irq_i[1];
      if (mip_o !== exp) begin
        report_mismatch("mip_o", mip_o, exp);
      end
      @(negedge clk_i);
    end
    ext_irq_i = 2'b00;
    finish_test("irq packing", err_start);
  endtask

  task automatic test_ndmreset();
    int                   err_start;
    int                   cycles;
    int unsigned          idx;
    logic [DataWidth-1:0] wdata;
    err_start = errors;
    idx       = $urandom % DramWords;
    wdata     = {$urandom, $urandom};
    bus_write(dram_addr(idx), '1, wdata);
    ndmreset_req_i = 1'b1;
    #1;
    if (core_rst_no !== 1'b0) begin
      report_mismatch("core_rst_no", 64'(core_rst_no), 64'd0);
    end
    repeat (2) @(negedge clk_i);
    ndmreset_req_i = 1'b0;
    cycles         = 0;
    while (!core_rst_no && cycles < 20) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!core_rst_no) begin
      abort_run("core_rst_no stayed low after ndmreset_req_i");
    end
    if (cycles != 2) begin
      report_mismatch("core_rst_no release cycle", 64'(cycles), 64'd2);
    end
    if (mip_o[IrqMsip] !== 1'b0) begin
      report_mismatch("mip_o msip", 64'(mip_o[IrqMsip]), 64'd0);
    end
    read_expect(clint_addr(MsipOffset), 64'd0, "msip");
    read_expect(clint_addr(MtimeOffset), 64'd0, "mtime");
    read_expect(clint_addr(MtimecmpOffset), '1, "mtimecmp");
    read_expect(dram_addr(idx), wdata, "bus_rdata_o");
    finish_test("ndmreset", err_start);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(32'h569));
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    rst_ni         = 1'b0;
    rtc_i          = 1'b0;
    ndmreset_req_i = 1'b0;
    dbg_enable_i   = 1'b1;
    dbg_halt_req_i = 1'b1;
    ext_irq_i      = 2'b00;
    bus_req_i      = 1'b0;
    bus_we_i       = 1'b0;
    bus_addr_i     = '0;
    bus_be_i       = '0;
    bus_wdata_i    = '0;
    $readmemh("hw/bootrom.hex", rom_model);
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    // hold-off counts from this edge, so it runs first
    test_debug_holdoff();
    test_dram();
    test_rom_and_errors();
    test_clint_timer();
    test_irq_packing();
    test_ndmreset();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog.f
hw/harness_pkg.sv
hw/rst_sync.sv
hw/dbg_gate.sv
hw/bus_demux.sv
hw/bootrom.sv
hw/dram_mem.sv
hw/clint_timer.sv
hw/soc_harness.sv
test/soc_harness_props.sv
test/tb_soc_harness.sv
